// File: Makefile
VERILATOR ?= verilator
TOP       := tb_flash_read
FILELIST  := src.f
OBJ_DIR   := obj_dir
VFLAGS    := --timing --timescale 1ns/100ps --top-module $(TOP)

SOURCES   := $(shell cat $(FILELIST))
SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) -Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status of the model is the pass or fail result
sim: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

// File: logic/flash_pkg.sv
`default_nettype none

package flash_pkg;

   typedef logic [7:0] cmd_t;

   localparam cmd_t CMD_READ = 8'h03; // read data
   localparam cmd_t CMD_WAKE = 8'hAB; // release from deep power-down

   // frame layout, MSB first on the wire
   localparam int CMD_BITS   = 8;
   localparam int ADDR_BITS  = 24;
   localparam int DATA_BITS  = 32;
   localparam int FRAME_BITS = CMD_BITS + ADDR_BITS + DATA_BITS;

   // SCK runs at clk/8
   localparam int SCK_DIV           = 8;
   localparam int SCK_RISE_PHASE    = 4; // sck high for phases 4..7
   localparam int MISO_SAMPLE_PHASE = 6; // well after the flash drives on the falling edge

   localparam int WAKE_WAIT = 16; // deselect time after the wake command

   localparam int DIV_W     = $clog2(SCK_DIV);
   localparam int BIT_CNT_W = $clog2(FRAME_BITS);
   localparam int WAIT_W    = $clog2(WAKE_WAIT);

   typedef logic [DIV_W-1:0]     div_t;
   typedef logic [BIT_CNT_W-1:0] bit_cnt_t;
   typedef logic [WAIT_W-1:0]    wait_t;

endpackage

`default_nettype wire

// File: logic/flash_read_top.sv
`timescale 1ns/100ps
`default_nettype none

module flash_read_top (
   input  logic            clk,
   input  logic            reset,
   input  logic            req_valid,
   output logic            req_ready,
   input  host_pkg::addr_t req_addr,
   output logic            rsp_valid,
   input  logic            rsp_ready,
   output host_pkg::word_t rsp_data,
   output logic            spi_sck,
   output logic            spi_ss,
   output logic            spi_mosi,
   input  logic            spi_miso
);

   logic            head_valid;
   logic            head_ready;
   host_pkg::addr_t head_addr;
   logic            rsp_push;
   host_pkg::word_t rsp_word;
   logic            credit_return;

   // addresses waiting for the flash
   sync_fifo #(
      .payload_t (host_pkg::addr_t),
      .DEPTH     (host_pkg::REQ_DEPTH)
   ) req_q (
      .clk           (clk),
      .reset         (reset),
      .in_valid      (req_valid),
      .in_ready      (req_ready),
      .in_data       (req_addr),
      .out_valid     (head_valid),
      .out_ready     (head_ready),
      .out_data      (head_addr),
      .credit_return ()
   );

   spi_flash_master master0 (
      .clk           (clk),
      .reset         (reset),
      .req_valid     (head_valid),
      .req_ready     (head_ready),
      .req_addr      (head_addr),
      .rsp_push      (rsp_push),
      .rsp_word      (rsp_word),
      .credit_return (credit_return),
      .spi_sck       (spi_sck),
      .spi_ss        (spi_ss),
      .spi_mosi      (spi_mosi),
      .spi_miso      (spi_miso)
   );

   // never full on push, the master holds a credit per word
   sync_fifo #(
      .payload_t (host_pkg::word_t),
      .DEPTH     (host_pkg::RSP_DEPTH)
   ) rsp_q (
      .clk           (clk),
      .reset         (reset),
      .in_valid      (rsp_push),
      .in_ready      (),
      .in_data       (rsp_word),
      .out_valid     (rsp_valid),
      .out_ready     (rsp_ready),
      .out_data      (rsp_data),
      .credit_return (credit_return)
   );

endmodule

`default_nettype wire

// File: logic/host_pkg.sv
`default_nettype none

package host_pkg;

   // host side payloads follow the flash frame fields
   typedef logic [flash_pkg::ADDR_BITS-1:0] addr_t;
   typedef logic [flash_pkg::DATA_BITS-1:0] word_t;

   // queue sizing
   localparam int REQ_DEPTH = 4;
   localparam int RSP_DEPTH = 4;

   // holds 0 up to RSP_DEPTH inclusive
   typedef logic [$clog2(RSP_DEPTH + 1)-1:0] credit_t;

endpackage

`default_nettype wire

// File: logic/spi_flash_master.sv
`timescale 1ns/100ps
`default_nettype none

module spi_flash_master (
   input  logic            clk,
   input  logic            reset,
   input  logic            req_valid,
   output logic            req_ready,
   input  host_pkg::addr_t req_addr,
   output logic            rsp_push,
   output host_pkg::word_t rsp_word,
   input  logic            credit_return,
   output logic            spi_sck,
   output logic            spi_ss,
   output logic            spi_mosi,
   input  logic            spi_miso
);

   typedef enum logic [1:0] {
      ST_WAKE_SEND,
      ST_WAKE_WAIT,
      ST_IDLE,
      ST_READ
   } state_t;

   state_t                              state;
   flash_pkg::div_t                     div_cnt;
   flash_pkg::bit_cnt_t                 bit_cnt;
   flash_pkg::wait_t                    wait_cnt;
   logic [flash_pkg::FRAME_BITS-1:0]    tx_shift;
   host_pkg::word_t                     rx_shift;
   host_pkg::credit_t                   credit_cnt;
   logic                                shifting;
   logic                                accept;
   logic                                bit_end;
   logic                                last_bit;
   logic                                wake_load;
   logic                                data_phase;

   // wake frame loads while ss is still high in its first cycle
   assign wake_load = (state == ST_WAKE_SEND) && spi_ss;
   assign shifting  = ((state == ST_WAKE_SEND) && !spi_ss) || (state == ST_READ);

   // take a request only with a free slot guaranteed in the response queue
   assign req_ready = (state == ST_IDLE) && (credit_cnt != '0);
   assign accept    = req_valid && req_ready;

   assign bit_end = shifting && (div_cnt == flash_pkg::div_t'(flash_pkg::SCK_DIV - 1));

   always_comb begin
      if (state == ST_READ) begin
         last_bit = bit_end
                    && (bit_cnt == flash_pkg::bit_cnt_t'(flash_pkg::FRAME_BITS - 1));
      end else begin
         last_bit = bit_end
                    && (bit_cnt == flash_pkg::bit_cnt_t'(flash_pkg::CMD_BITS - 1));
      end
   end

   // bits past command and address carry flash data
   assign data_phase = (bit_cnt >= flash_pkg::bit_cnt_t'(flash_pkg::CMD_BITS
                                                         + flash_pkg::ADDR_BITS));

   assign spi_mosi = tx_shift[flash_pkg::FRAME_BITS-1]; // msb leads, zero fill after
   assign rsp_word = rx_shift;

   // divider and bit position within the frame
   always_ff @(posedge clk) begin
      if (reset) begin
         div_cnt <= '0;
         bit_cnt <= '0;
      end else begin
         if (!shifting || bit_end) begin
            div_cnt <= '0;
         end else begin
            div_cnt <= div_cnt + 1'b1;
         end
         if (last_bit) begin
            bit_cnt <= '0;
         end else if (bit_end) begin
            bit_cnt <= bit_cnt + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         spi_sck <= 1'b0;
      end else if (shifting
                   && (div_cnt == flash_pkg::div_t'(flash_pkg::SCK_RISE_PHASE - 1))) begin
         spi_sck <= 1'b1;
      end else if (bit_end) begin
         spi_sck <= 1'b0; // low again from phase 0
      end
   end

   // outgoing bits, next one shows up at phase 0
   always_ff @(posedge clk) begin
      if (reset) begin
         tx_shift <= '0;
      end else if (accept) begin
         tx_shift <= {flash_pkg::CMD_READ, req_addr, {flash_pkg::DATA_BITS{1'b0}}};
      end else if (wake_load) begin
         tx_shift <= {flash_pkg::CMD_WAKE,
                      {(flash_pkg::FRAME_BITS - flash_pkg::CMD_BITS){1'b0}}};
      end else if (bit_end) begin
         tx_shift <= {tx_shift[flash_pkg::FRAME_BITS-2:0], 1'b0};
      end
   end

   always_ff @(posedge clk) begin
      if ((state == ST_READ) && data_phase
          && (div_cnt == flash_pkg::div_t'(flash_pkg::MISO_SAMPLE_PHASE))) begin
         rx_shift <= {rx_shift[flash_pkg::DATA_BITS-2:0], spi_miso};
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state    <= ST_WAKE_SEND;
         spi_ss   <= 1'b1;
         rsp_push <= 1'b0;
         wait_cnt <= '0;
      end else begin
         rsp_push <= 1'b0;
         case (state)
            ST_WAKE_SEND: begin
               if (spi_ss) begin
                  spi_ss <= 1'b0; // select for the wake command
               end else if (last_bit) begin
                  spi_ss <= 1'b1;
                  state  <= ST_WAKE_WAIT;
               end
            end
            ST_WAKE_WAIT: begin
               wait_cnt <= wait_cnt + 1'b1;
               if (wait_cnt == flash_pkg::wait_t'(flash_pkg::WAKE_WAIT - 1)) begin
                  wait_cnt <= '0;
                  state    <= ST_IDLE;
               end
            end
            ST_IDLE: begin
               if (accept) begin
                  spi_ss <= 1'b0;
                  state  <= ST_READ;
               end
            end
            ST_READ: begin
               if (last_bit) begin
                  spi_ss   <= 1'b1;
                  rsp_push <= 1'b1; // word complete in rx_shift
                  state    <= ST_IDLE;
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   // credits mirror free slots in the response queue
   always_ff @(posedge clk) begin
      if (reset) begin
         credit_cnt <= host_pkg::credit_t'(host_pkg::RSP_DEPTH);
      end else begin
         case ({accept, credit_return})
            2'b10:   credit_cnt <= credit_cnt - 1'b1;
            2'b01:   credit_cnt <= credit_cnt + 1'b1;
            default: credit_cnt <= credit_cnt;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: logic/sync_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module sync_fifo #(
   parameter type payload_t = logic,
   parameter int  DEPTH     = 2
) (
   input  logic     clk,
   input  logic     reset,
   input  logic     in_valid,
   output logic     in_ready,
   input  payload_t in_data,
   output logic     out_valid,
   input  logic     out_ready,
   output payload_t out_data,
   output logic     credit_return
);

   localparam int PTR_W = $clog2(DEPTH);
   localparam int CNT_W = $clog2(DEPTH + 1);

   payload_t         mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             push;
   logic             pop;

   assign in_ready  = (count != CNT_W'(DEPTH));
   assign out_valid = (count != '0);
   assign out_data  = mem[rd_ptr]; // head is shown as soon as it is written

   assign push = in_valid && in_ready;
   assign pop  = out_valid && out_ready;

   // one credit back for every word that leaves
   assign credit_return = pop;

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= in_data;
      end
   end

   // pointers wrap by compare so any depth works, not just powers of two
   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (push) begin
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         count <= '0;
      end else begin
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count; // both or neither
         endcase
      end
   end

endmodule

`default_nettype wire

// File: src.f
logic/flash_pkg.sv
logic/host_pkg.sv
logic/sync_fifo.sv
logic/spi_flash_master.sv
logic/flash_read_top.sv
tb/tb_clock_gen.sv
tb/spi_flash_model.sv
tb/tb_flash_read.sv

// File: tb/spi_flash_model.sv
`timescale 1ns/100ps
`default_nettype none

module spi_flash_model #(
   parameter logic [31:0] MUL   = 32'h9E3779B1, // odd, so every address maps to its own word
   parameter int          SHIFT = 7
) (
   input  logic            spi_sck,
   input  logic            spi_ss,
   input  logic            spi_mosi,
   output logic            spi_miso,
   output flash_pkg::cmd_t cmd,
   output host_pkg::addr_t addr,
   output int              sck_edges,
   output logic            bad_cmd
);

   flash_pkg::cmd_t cmd_q      = '0;
   flash_pkg::cmd_t next_cmd;
   host_pkg::addr_t addr_q     = '0;
   int              edges_q    = 0;
   logic            bad_q      = 1'b0;
   logic            miso_q     = 1'b0;
   host_pkg::word_t data_shift = '0;

   assign spi_miso  = miso_q;
   assign cmd       = cmd_q;
   assign addr      = addr_q;
   assign sck_edges = edges_q;
   assign bad_cmd   = bad_q; // sticky
   assign next_cmd  = {cmd_q[6:0], spi_mosi};

   // array contents, a pure function of the address
   function automatic host_pkg::word_t stored_word(input host_pkg::addr_t a);
      host_pkg::word_t w;
      w = host_pkg::word_t'(a);
      return (w * MUL) ^ (w << SHIFT);
   endfunction

   // command and address come in on rising sck, falling ss restarts the count
   always @(posedge spi_sck or negedge spi_ss) begin
      if (!spi_sck) begin
         edges_q <= 0;
      end else begin
         if (edges_q < flash_pkg::CMD_BITS) begin
            cmd_q <= next_cmd;
         end else if (edges_q < flash_pkg::CMD_BITS + flash_pkg::ADDR_BITS) begin
            addr_q <= {addr_q[flash_pkg::ADDR_BITS-2:0], spi_mosi};
         end
         if ((edges_q == flash_pkg::CMD_BITS - 1)
             && (next_cmd != flash_pkg::CMD_WAKE) && (next_cmd != flash_pkg::CMD_READ)) begin
            bad_q <= 1'b1;
         end
         edges_q <= edges_q + 1;
      end
   end

   // read data leaves on falling sck once the last address bit is in
   always @(negedge spi_sck) begin
      if ((cmd_q == flash_pkg::CMD_READ)
          && (edges_q == flash_pkg::CMD_BITS + flash_pkg::ADDR_BITS)) begin
         {miso_q, data_shift} <= {stored_word(addr_q), 1'b0};
      end else begin
         {miso_q, data_shift} <= {data_shift, 1'b0}; // zeros once drained
      end
   end

endmodule

`default_nettype wire

// File: tb/tb_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
   parameter int PERIOD       = 40, // ns
   parameter int RESET_CYCLES = 8
) (
   output logic clk,
   output logic reset
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

   // release on a falling edge, same as all other stimulus
   initial begin
      reset = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
   end

endmodule

`default_nettype wire

// File: tb/tb_flash_read.sv
`timescale 1ns/100ps
`default_nettype none

module tb_flash_read;

   localparam int          CLK_PERIOD   = 40;
   localparam int          RESET_CYCLES = 8;
   localparam int          NUM_REQ      = 40;
   localparam logic [31:0] LFSR_SEED    = 32'h5e7f6dd2;
   localparam logic [31:0] DATA_MUL     = 32'h9E3779B1;
   localparam int          DATA_SHIFT   = 7;
   localparam int          FRAME_CYCLES = flash_pkg::FRAME_BITS * flash_pkg::SCK_DIV;
   localparam int          HOLD_CYCLES  = 2 * FRAME_CYCLES;
   localparam int          WAKE_CYCLES  = flash_pkg::CMD_BITS * flash_pkg::SCK_DIV
                                          + flash_pkg::WAKE_WAIT;
   localparam int          WATCHDOG_CYCLES = NUM_REQ * FRAME_CYCLES * 2 + WAKE_CYCLES
                                             + RESET_CYCLES + HOLD_CYCLES;

   logic            clk;
   logic            reset;
   logic            req_valid;
   logic            req_ready;
   host_pkg::addr_t req_addr;
   logic            rsp_valid;
   logic            rsp_ready;
   host_pkg::word_t rsp_data;
   logic            spi_sck;
   logic            spi_ss;
   logic            spi_mosi;
   logic            spi_miso;
   flash_pkg::cmd_t flash_cmd;
   host_pkg::addr_t flash_addr;
   int              flash_edges;
   logic            flash_bad_cmd;

   logic [31:0]     lfsr = LFSR_SEED;
   host_pkg::addr_t addr_list [NUM_REQ];
   int              gap_list  [NUM_REQ];
   host_pkg::addr_t exp_addr_q [$];
   host_pkg::word_t exp_word_q [$];
   int              frames_ended = 0;
   int              reads_done   = 0;
   int              words_seen   = 0;

   tb_clock_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) clkgen0 (
      .clk   (clk),
      .reset (reset)
   );

   flash_read_top dut0 (
      .clk       (clk),
      .reset     (reset),
      .req_valid (req_valid),
      .req_ready (req_ready),
      .req_addr  (req_addr),
      .rsp_valid (rsp_valid),
      .rsp_ready (rsp_ready),
      .rsp_data  (rsp_data),
      .spi_sck   (spi_sck),
      .spi_ss    (spi_ss),
      .spi_mosi  (spi_mosi),
      .spi_miso  (spi_miso)
   );

   spi_flash_model #(.MUL(DATA_MUL), .SHIFT(DATA_SHIFT)) flash0 (
      .spi_sck   (spi_sck),
      .spi_ss    (spi_ss),
      .spi_mosi  (spi_mosi),
      .spi_miso  (spi_miso),
      .cmd       (flash_cmd),
      .addr      (flash_addr),
      .sck_edges (flash_edges),
      .bad_cmd   (flash_bad_cmd)
   );

   // galois form with taps 32 22 2 1
   function automatic logic lfsr_step();
      logic lsb;
      lsb  = lfsr[0];
      lfsr = lfsr >> 1;
      if (lsb) lfsr = lfsr ^ 32'h80200003;
      return lsb;
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) v = {v[30:0], lfsr_step()};
      return v;
   endfunction

   // what the flash holds at an address
   function automatic host_pkg::word_t flash_word(input host_pkg::addr_t a);
      host_pkg::word_t w;
      w = host_pkg::word_t'(a);
      return (w * DATA_MUL) ^ (w << DATA_SHIFT);
   endfunction

   task automatic fail_now(input string msg);
      $display("%s", msg);
      $display("Simulation FAILED");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic check_word(input string what, input host_pkg::word_t got,
                             input host_pkg::word_t exp);
      if (got !== exp) fail_now($sformatf("mismatch at %0t: %s got %h expected %h",
                                          $time, what, got, exp));
   endtask

   task automatic check_addr(input string what, input host_pkg::addr_t got,
                             input host_pkg::addr_t exp);
      if (got !== exp) fail_now($sformatf("mismatch at %0t: %s got %h expected %h",
                                          $time, what, got, exp));
   endtask

   task automatic check_cmd(input string what, input flash_pkg::cmd_t got,
                            input flash_pkg::cmd_t exp);
      if (got !== exp) fail_now($sformatf("mismatch at %0t: %s got %h expected %h",
                                          $time, what, got, exp));
   endtask

   task automatic check_count(input string what, input int got, input int exp);
      if (got != exp) fail_now($sformatf("mismatch at %0t: %s got %0d expected %0d",
                                         $time, what, got, exp));
   endtask

   // model outputs are settled by the first falling clk after ss rises
   task automatic check_frame_end();
      if (flash_bad_cmd) fail_now("flash model received a command it does not support");
      if (frames_ended == 0) begin
         check_cmd("first command", flash_cmd, flash_pkg::CMD_WAKE);
         check_count("sck edges in wake frame", flash_edges, flash_pkg::CMD_BITS);
      end else begin
         check_cmd("read command", flash_cmd, flash_pkg::CMD_READ);
         if (exp_addr_q.size() == 0) fail_now("flash read started with no accepted request");
         check_addr("flash address", flash_addr, exp_addr_q.pop_front());
         check_count("sck edges in read frame", flash_edges, flash_pkg::FRAME_BITS);
         reads_done++;
      end
      frames_ended++;
   endtask

   task automatic drive_requests();
      for (int i = 0; i < NUM_REQ; i++) begin
         repeat (gap_list[i]) @(negedge clk);
         req_valid = 1'b1;
         req_addr  = addr_list[i];
         while (!req_ready) @(negedge clk);
         exp_addr_q.push_back(addr_list[i]); // taken on the coming rising edge
         exp_word_q.push_back(flash_word(addr_list[i]));
         @(negedge clk);
         req_valid = 1'b0;
      end
   endtask

   task automatic collect_responses();
      rsp_ready = 1'b0;
      while (req_ready) @(negedge clk); // request queue backs up
      while (reads_done < host_pkg::RSP_DEPTH) @(negedge clk);
      repeat (HOLD_CYCLES) begin
         @(negedge clk);
         if (!spi_ss || spi_sck) fail_now("flash was accessed while no credit was left");
         if (req_ready) fail_now("request queue accepted more while the path was stalled");
         if (!rsp_valid) fail_now("held responses disappeared from the response queue");
      end
      while (words_seen < NUM_REQ) begin
         @(negedge clk);
         rsp_ready = (rand_bits(2) != '0);
         if (rsp_valid && rsp_ready) begin
            if (exp_word_q.size() == 0) fail_now("response arrived with no request pending");
            check_word("response data", rsp_data, exp_word_q.pop_front());
            words_seen++;
         end
      end
      @(negedge clk);
      rsp_ready = 1'b0;
   endtask

   // bus checks on every falling clk
   initial begin : spi_monitor
      logic prev_ss;
      int   high_cnt;
      prev_ss  = 1'b1;
      high_cnt = 0;
      forever begin
         @(negedge clk);
         if (!reset) begin
            if (spi_ss && spi_sck) fail_now("SCK was high while the flash was deselected");
            if (prev_ss && !spi_ss) begin
               if ((frames_ended == 1) && (high_cnt < flash_pkg::WAKE_WAIT)) begin
                  fail_now("first read started before the wake-up wait was over");
               end
            end else if (!prev_ss && spi_ss) begin
               check_frame_end();
            end
            high_cnt = spi_ss ? high_cnt + 1 : 0;
         end
         prev_ss = spi_ss;
      end
   end

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
      $display("Simulation FAILED");
      $fatal(1, "watchdog expired");
   end

   initial begin
      req_valid = 1'b0;
      req_addr  = '0;
      rsp_ready = 1'b0;
      for (int i = 0; i < NUM_REQ; i++) begin
         addr_list[i] = host_pkg::addr_t'(rand_bits(flash_pkg::ADDR_BITS));
         gap_list[i]  = int'(rand_bits(2));
      end
      @(negedge clk);
      while (reset) @(negedge clk);
      fork
         drive_requests();
         collect_responses();
      join
      if ((words_seen == NUM_REQ) && (reads_done == NUM_REQ)
          && (exp_addr_q.size() == 0) && (exp_word_q.size() == 0)) begin
         $display("Simulation PASSED");
         $finish;
      end else begin
         $display("run ended with requests that never completed");
         $display("Simulation FAILED");
         $fatal(1, "incomplete run");
      end
   end

endmodule

`default_nettype wire
